/* include/core_settings.svh */
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// byte address of the very first instruction fetch
`define CORE_RESET_PC 16'h0000

// general purpose registers held inside decode
`define CORE_NUM_REGS 8

`endif

/* rtl/corePkg.sv */
package corePkg;

   // data and instruction words share one width
   typedef logic [15:0] word_t;
   // byte address, always word aligned
   typedef logic [15:0] addr_t;
   typedef logic [2:0] regAddr_t;
   // major opcode from instr[15:11]
   typedef logic [4:0] opcode_t;
   // register-register function from instr[1:0]
   typedef logic [1:0] aluFunc_t;

   localparam opcode_t OP_HALT = 5'b00000;
   localparam opcode_t OP_NOP = 5'b00001;
   localparam opcode_t OP_J = 5'b00100;
   localparam opcode_t OP_ADDI = 5'b01000;
   // branch group, low two bits pick the condition on Rs
   localparam opcode_t OP_BEQZ = 5'b01100;
   localparam opcode_t OP_BNEZ = 5'b01101;
   localparam opcode_t OP_BLTZ = 5'b01110;
   localparam opcode_t OP_BGEZ = 5'b01111;
   localparam opcode_t OP_ST = 5'b10000;
   localparam opcode_t OP_LD = 5'b10001;
   localparam opcode_t OP_LBI = 5'b11000;
   localparam opcode_t OP_ALU = 5'b11011;

   localparam aluFunc_t FN_ADD = 2'b00;
   localparam aluFunc_t FN_SUB = 2'b01;
   localparam aluFunc_t FN_AND = 2'b10;
   localparam aluFunc_t FN_XOR = 2'b11;

   // fetch side, idle / bus read outstanding / word held for decode
   typedef enum logic [1:0] {F_IDLE, F_REQ, F_HOLD} fetchState_t;

   // execute side, idle / writeback cycle / data bus access
   typedef enum logic [1:0] {E_IDLE, E_ALU, E_MEM} execState_t;

endpackage

/* rtl/coreIfs.sv */
`timescale 1ns/100ps

// wishbone classic, one master and one slave per instance
interface wbBus;
   logic cyc;
   logic stb;
   logic we;
   corePkg::addr_t adr;
   corePkg::word_t datWr;
   corePkg::word_t datRd;
   logic ack;

   modport master (output cyc, stb, we, adr, datWr, input datRd, ack);
   modport slave (input cyc, stb, we, adr, datWr, output datRd, ack);
endinterface

// fetch to decode handoff, redirect flows back toward fetch
interface instrLink;
   logic valid;
   corePkg::word_t instr;
   corePkg::addr_t pc;
   logic ready;
   logic redirect;
   corePkg::addr_t target;

   modport fetch (output valid, instr, pc, input ready, redirect, target);
   modport decode (input valid, instr, pc, output ready, redirect, target);
endinterface

/* rtl/fetch.sv */
`timescale 1ns/100ps
`include "core_settings.svh"

module fetch (
   input logic clk,
   input logic rst,
   wbBus.master bus,
   instrLink.fetch link
);
   corePkg::fetchState_t state;
   // address of the word being read or held
   corePkg::addr_t pc;
   corePkg::word_t held;
   // low through the first cycle out of reset
   logic started;
   logic xfer;

   assign xfer = link.valid & link.ready;

   // read only master, request held steady while in F_REQ
   assign bus.cyc = (state == corePkg::F_REQ);
   assign bus.stb = (state == corePkg::F_REQ);
   assign bus.we = 1'b0;
   assign bus.adr = pc;
   assign bus.datWr = '0;

   assign link.valid = (state == corePkg::F_HOLD);
   assign link.instr = held;
   assign link.pc = pc;

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= corePkg::F_IDLE;
         pc <= `CORE_RESET_PC;
         started <= 1'b0;
      end else begin
         case (state)
            corePkg::F_IDLE: begin
               // one quiet cycle after reset, then the first read
               started <= 1'b1;
               if (started) begin
                  state <= corePkg::F_REQ;
               end
            end
            corePkg::F_REQ: begin
               // address stays put until ack
               if (bus.ack) begin
                  held <= bus.datRd;
                  state <= corePkg::F_HOLD;
               end
            end
            corePkg::F_HOLD: begin
               // next sequential read starts right after the handoff
               if (xfer) begin
                  pc <= link.redirect ? link.target : pc + 16'd2;
                  state <= corePkg::F_REQ;
               end
            end
            default: state <= corePkg::F_IDLE;
         endcase
      end
   end

endmodule

/* rtl/decode.sv */
`timescale 1ns/100ps
`include "core_settings.svh"

module decode (
   input logic clk,
   input logic rst,
   instrLink.decode link,
   input logic busy,
   input logic wbEn,
   input corePkg::regAddr_t wbAddr,
   input corePkg::word_t wbData,
   output logic issue,
   output corePkg::opcode_t op,
   output corePkg::aluFunc_t aluFunc,
   output corePkg::regAddr_t dest,
   output corePkg::word_t operandA,
   output corePkg::word_t operandB,
   output corePkg::word_t storeData,
   output logic halted
);
   corePkg::word_t regs [`CORE_NUM_REGS];
   corePkg::opcode_t opc;
   corePkg::regAddr_t rs, rt, rd, destSel;
   corePkg::word_t rsVal, rtVal, imm8, imm5, imm11, opBSel;
   logic pending;
   corePkg::regAddr_t pendDest;
   logic xfer, isBranch, isJump, isHalt, taken, zeroFlag, signFlag;
   logic writesReg, doesIssue;

   // field split straight off the link
   assign opc = link.instr[15:11];
   assign rs = link.instr[10:8];
   assign rt = link.instr[7:5];
   assign rd = link.instr[4:2];
   assign imm8 = {{8{link.instr[7]}}, link.instr[7:0]};
   assign imm5 = {{11{link.instr[4]}}, link.instr[4:0]};
   assign imm11 = {{5{link.instr[10]}}, link.instr[10:0]};

   // two async reads, regs are already up to date at handoff
   assign rsVal = regs[rs];
   assign rtVal = regs[rt];

   // one instruction at a time, wait out execute and its writeback
   assign link.ready = ~halted & ~busy & ~pending & ~issue;
   assign xfer = link.valid & link.ready;

   assign isBranch = (opc[4:2] == 3'b011);
   assign isJump = (opc == corePkg::OP_J);
   assign isHalt = (opc == corePkg::OP_HALT);
   assign zeroFlag = (rsVal == '0);
   assign signFlag = rsVal[15];

   always_comb begin
      case (opc[1:0])
         2'b00: taken = zeroFlag;
         2'b01: taken = ~zeroFlag;
         2'b10: taken = signFlag;
         default: taken = ~signFlag;
      endcase
   end

   // halt parks fetch on its own address so nothing past it is read
   assign link.redirect = xfer & ((isBranch & taken) | isJump | isHalt);
   assign link.target = isHalt ? link.pc : link.pc + 16'd2 + (isJump ? imm11 : imm8);

   assign writesReg = (opc == corePkg::OP_ALU) | (opc == corePkg::OP_ADDI) |
                      (opc == corePkg::OP_LBI) | (opc == corePkg::OP_LD);
   assign doesIssue = writesReg | (opc == corePkg::OP_ST);

   // destination and second operand per format
   always_comb begin
      case (opc)
         corePkg::OP_ALU: begin
            destSel = rd;
            opBSel = rtVal;
         end
         corePkg::OP_LD, corePkg::OP_ST: begin
            destSel = rt;
            opBSel = imm5;
         end
         default: begin
            // LBI and ADDI target Rs
            destSel = rs;
            opBSel = imm8;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (wbEn) begin
         regs[wbAddr] <= wbData;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         issue <= 1'b0;
         pending <= 1'b0;
         halted <= 1'b0;
      end else begin
         issue <= xfer & doesIssue;
         if (xfer & isHalt) begin
            halted <= 1'b1;
         end
         // block the next handoff until this register lands
         if (xfer & writesReg) begin
            pending <= 1'b1;
            pendDest <= destSel;
         end else if (wbEn && (wbAddr == pendDest)) begin
            pending <= 1'b0;
         end
      end
   end

   // operands for execute, held until the next handoff
   always_ff @(posedge clk) begin
      if (xfer) begin
         op <= opc;
         aluFunc <= link.instr[1:0];
         dest <= destSel;
         operandA <= rsVal;
         operandB <= opBSel;
         storeData <= rtVal;
      end
   end

endmodule

/* rtl/execute.sv */
`timescale 1ns/100ps

module execute (
   input logic clk,
   input logic rst,
   input logic issue,
   input corePkg::opcode_t op,
   input corePkg::aluFunc_t aluFunc,
   input corePkg::regAddr_t dest,
   input corePkg::word_t operandA,
   input corePkg::word_t operandB,
   input corePkg::word_t storeData,
   wbBus.master bus,
   output logic busy,
   output logic wbEn,
   output corePkg::regAddr_t wbAddr,
   output corePkg::word_t wbData
);
   corePkg::execState_t state;
   corePkg::word_t result;
   logic isMem;
   // latched bus request for the whole access
   corePkg::addr_t memAddr;
   corePkg::word_t memData;
   logic memWe;

   assign isMem = (op == corePkg::OP_LD) | (op == corePkg::OP_ST);

   // one adder also forms the load/store address
   always_comb begin
      case (op)
         corePkg::OP_LBI: result = operandB;
         corePkg::OP_ALU: begin
            case (aluFunc)
               corePkg::FN_ADD: result = operandA + operandB;
               // Rs minus Rt
               corePkg::FN_SUB: result = operandA - operandB;
               corePkg::FN_AND: result = operandA & operandB;
               default: result = operandA ^ operandB;
            endcase
         end
         default: result = operandA + operandB;
      endcase
   end

   assign busy = (state != corePkg::E_IDLE);

   assign bus.cyc = (state == corePkg::E_MEM);
   assign bus.stb = (state == corePkg::E_MEM);
   assign bus.we = memWe;
   assign bus.adr = memAddr;
   assign bus.datWr = memData;

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= corePkg::E_IDLE;
         wbEn <= 1'b0;
      end else begin
         // single cycle strobe
         wbEn <= 1'b0;
         case (state)
            corePkg::E_IDLE: begin
               if (issue) begin
                  wbAddr <= dest;
                  if (isMem) begin
                     memAddr <= result;
                     memData <= storeData;
                     memWe <= (op == corePkg::OP_ST);
                     state <= corePkg::E_MEM;
                  end else begin
                     wbEn <= 1'b1;
                     wbData <= result;
                     state <= corePkg::E_ALU;
                  end
               end
            end
            corePkg::E_ALU: begin
               // writeback is on the bus this cycle
               state <= corePkg::E_IDLE;
            end
            corePkg::E_MEM: begin
               // slave may stretch this as long as it likes
               if (bus.ack) begin
                  state <= corePkg::E_IDLE;
                  if (!memWe) begin
                     wbEn <= 1'b1;
                     wbData <= bus.datRd;
                  end
               end
            end
            default: state <= corePkg::E_IDLE;
         endcase
      end
   end

endmodule

/* rtl/wbArbiter.sv */
`timescale 1ns/100ps

module wbArbiter (
   input logic clk,
   input logic rst,
   wbBus.slave fetchBus,
   wbBus.slave dataBus,
   output logic cyc,
   output logic stb,
   output logic we,
   output corePkg::addr_t adr,
   output corePkg::word_t datWr,
   input corePkg::word_t datRd,
   input logic ack
);
   // grant held across wait states
   logic owned;
   logic ownerData;
   // current selection, data side when set
   logic selData;

   // free bus goes to execute first, otherwise stay with the owner
   assign selData = owned ? ownerData : dataBus.cyc;

   // plain mux, no added cycle
   always_comb begin
      if (selData) begin
         cyc = dataBus.cyc;
         stb = dataBus.stb;
         we = dataBus.we;
         adr = dataBus.adr;
         datWr = dataBus.datWr;
      end else begin
         cyc = fetchBus.cyc;
         stb = fetchBus.stb;
         we = fetchBus.we;
         adr = fetchBus.adr;
         datWr = fetchBus.datWr;
      end
   end

   // the master that lost sees neither ack nor data
   assign dataBus.ack = selData & ack;
   assign fetchBus.ack = ~selData & ack;
   assign dataBus.datRd = selData ? datRd : '0;
   assign fetchBus.datRd = selData ? '0 : datRd;

   always_ff @(posedge clk) begin
      if (rst) begin
         owned <= 1'b0;
         ownerData <= 1'b0;
      end else if (owned) begin
         if (ack) begin
            owned <= 1'b0;
         end
      end else if (cyc && !ack) begin
         // zero wait access finishes without locking
         owned <= 1'b1;
         ownerData <= selData;
      end
   end

endmodule

/* rtl/cpuTop.sv */
`timescale 1ns/100ps

module cpuTop (
   input logic clk,
   input logic rst,
   output logic wbCyc,
   output logic wbStb,
   output logic wbWe,
   output corePkg::addr_t wbAdr,
   output corePkg::word_t wbDatWr,
   input corePkg::word_t wbDatRd,
   input logic wbAck,
   output logic halted
);
   wbBus fetchBus ();
   wbBus dataBus ();
   instrLink link ();

   // decode to execute
   logic issue;
   corePkg::opcode_t op;
   corePkg::aluFunc_t aluFunc;
   corePkg::regAddr_t dest;
   corePkg::word_t operandA, operandB, storeData;
   // execute back to decode
   logic busy, wbEn;
   corePkg::regAddr_t wbAddr;
   corePkg::word_t wbData;

   fetch fetch0 (
      .clk(clk), .rst(rst), .bus(fetchBus), .link(link)
   );

   decode decode0 (
      .clk(clk), .rst(rst), .link(link),
      .busy(busy), .wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData),
      .issue(issue), .op(op), .aluFunc(aluFunc), .dest(dest),
      .operandA(operandA), .operandB(operandB), .storeData(storeData),
      .halted(halted)
   );

   execute execute0 (
      .clk(clk), .rst(rst), .issue(issue), .op(op), .aluFunc(aluFunc), .dest(dest),
      .operandA(operandA), .operandB(operandB), .storeData(storeData),
      .bus(dataBus), .busy(busy), .wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData)
   );

   // execute beats fetch on the shared memory bus
   wbArbiter arb0 (
      .clk(clk), .rst(rst), .fetchBus(fetchBus), .dataBus(dataBus),
      .cyc(wbCyc), .stb(wbStb), .we(wbWe), .adr(wbAdr), .datWr(wbDatWr),
      .datRd(wbDatRd), .ack(wbAck)
   );

endmodule

/* verification/cpuTb.sv */
`timescale 1ns/100ps
`include "core_settings.svh"

module cpuTb;
   logic clk, rst, wbAck, halted, wbCyc, wbStb, wbWe;
   corePkg::addr_t wbAdr;
   corePkg::word_t wbDatWr, wbDatRd;

   // program image, model memory and reference memory
   corePkg::word_t image [256];
   corePkg::word_t mem [256];
   corePkg::word_t refMem [256];
   corePkg::addr_t refAddr [$], dutAddr [$];
   corePkg::word_t refData [$], dutData [$];
   corePkg::addr_t haltPc;
   int seed = 82;
   int progLen, waitLeft, errors, passes, fails, cycles, limit;
   bit useWaits, checking, haltSeen;

   cpuTop dut0 (
      .clk(clk), .rst(rst), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe),
      .wbAdr(wbAdr), .wbDatWr(wbDatWr), .wbDatRd(wbDatRd), .wbAck(wbAck),
      .halted(halted)
   );

   always #10 clk = ~clk;

   task automatic checkWord(string name, corePkg::word_t got, corePkg::word_t exp);
      if (got !== exp) begin
         $display("[ERROR] %s got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic checkAddr(string name, corePkg::addr_t got, corePkg::addr_t exp);
      if (got !== exp) begin
         $display("[ERROR] %s got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   // instruction encoders
   task automatic put(corePkg::word_t w);
      image[progLen] = w;
      progLen++;
   endtask
   function automatic corePkg::word_t encI(corePkg::opcode_t o, int rs, int imm);
      return {o, rs[2:0], imm[7:0]};
   endfunction
   function automatic corePkg::word_t encR(int rs, int rt, int rd, corePkg::aluFunc_t f);
      return {corePkg::OP_ALU, rs[2:0], rt[2:0], rd[2:0], f};
   endfunction
   function automatic corePkg::word_t encM(corePkg::opcode_t o, int rs, int rt, int imm);
      return {o, rs[2:0], rt[2:0], imm[4:0]};
   endfunction
   function automatic corePkg::word_t encJ(int imm);
      return {corePkg::OP_J, imm[10:0]};
   endfunction

   // instruction-set model, returns the number of executed instructions
   function automatic int refRun();
      corePkg::word_t r [8];
      corePkg::word_t ins, a, s8, s5;
      corePkg::opcode_t o;
      corePkg::addr_t pc;
      int n;
      bit cond;
      pc = `CORE_RESET_PC;
      n = 0;
      for (int i = 0; i < 8; i++) r[i] = '0;
      refAddr.delete();
      refData.delete();
      for (int i = 0; i < 256; i++) refMem[i] = image[i];
      while (n < 2000) begin
         ins = refMem[pc[8:1]];
         o = ins[15:11];
         s8 = {{8{ins[7]}}, ins[7:0]};
         s5 = {{11{ins[4]}}, ins[4:0]};
         n++;
         if (o == corePkg::OP_HALT) begin
            haltPc = pc;
            break;
         end
         a = r[ins[10:8]] + s5;
         case (o)
            corePkg::OP_J: pc = pc + 16'd2 + {{5{ins[10]}}, ins[10:0]};
            corePkg::OP_ADDI: r[ins[10:8]] = r[ins[10:8]] + s8;
            corePkg::OP_LBI: r[ins[10:8]] = s8;
            corePkg::OP_LD: r[ins[7:5]] = refMem[a[8:1]];
            corePkg::OP_ST: begin
               refMem[a[8:1]] = r[ins[7:5]];
               refAddr.push_back(a);
               refData.push_back(r[ins[7:5]]);
            end
            corePkg::OP_ALU: begin
               case (ins[1:0])
                  2'b00: r[ins[4:2]] = r[ins[10:8]] + r[ins[7:5]];
                  2'b01: r[ins[4:2]] = r[ins[10:8]] - r[ins[7:5]];
                  2'b10: r[ins[4:2]] = r[ins[10:8]] & r[ins[7:5]];
                  default: r[ins[4:2]] = r[ins[10:8]] ^ r[ins[7:5]];
               endcase
            end
            default: ;
         endcase
         // branch on the sign and zero of Rs
         if (o[4:2] == 3'b011) begin
            case (o[1:0])
               2'b00: cond = (r[ins[10:8]] == 0);
               2'b01: cond = (r[ins[10:8]] != 0);
               2'b10: cond = r[ins[10:8]][15];
               default: cond = !r[ins[10:8]][15];
            endcase
            pc = cond ? pc + 16'd2 + s8 : pc + 16'd2;
         end else if (o != corePkg::OP_J) begin
            pc = pc + 16'd2;
         end
      end
      return n;
   endfunction

   // r7 becomes 0x100, start of the data region
   task automatic putBase();
      put(encI(corePkg::OP_LBI, 7, 8'h40));
      put(encI(corePkg::OP_ADDI, 7, 8'h40));
      put(encR(7, 7, 7, corePkg::FN_ADD));
   endtask

   task automatic buildProgram(int prog);
      progLen = 0;
      // fill depends on every address bit
      for (int i = 0; i < 256; i++) image[i] = 16'hA500 ^ (i * 16'h0101);
      putBase();
      case (prog)
         0: begin
            put(encI(corePkg::OP_LBI, 1, 8'h35));
            put(encI(corePkg::OP_LBI, 2, -7));
            put(encI(corePkg::OP_ADDI, 1, 8'h10));
            for (int f = 0; f < 4; f++) put(encR(1, 2, 3 + f, f[1:0]));
            for (int k = 1; k < 7; k++) put(encM(corePkg::OP_ST, 7, k, 2 * k));
         end
         1: begin
            put(encI(corePkg::OP_LBI, 1, 8'h12));
            put(encI(corePkg::OP_LBI, 2, -100));
            put(encM(corePkg::OP_ST, 7, 1, 4));
            put(encM(corePkg::OP_ST, 7, 2, -4));
            put(encM(corePkg::OP_LD, 7, 3, 4));
            put(encM(corePkg::OP_LD, 7, 4, -4));
            put(encI(corePkg::OP_ADDI, 7, 8));
            put(encM(corePkg::OP_ST, 7, 3, 14));
            put(encM(corePkg::OP_ST, 7, 4, -16));
            put(encM(corePkg::OP_ST, 7, 4, 0));
         end
         default: begin
            put(encI(corePkg::OP_LBI, 1, 0));
            put(encI(corePkg::OP_LBI, 2, 5));
            put(encI(corePkg::OP_LBI, 3, -3));
            // each condition taken then not taken, skipped store follows taken
            put(encI(corePkg::OP_BEQZ, 1, 2));
            put(encM(corePkg::OP_ST, 7, 2, 0));
            put(encI(corePkg::OP_BEQZ, 2, 2));
            put(encM(corePkg::OP_ST, 7, 2, 2));
            put(encI(corePkg::OP_BNEZ, 2, 2));
            put(encM(corePkg::OP_ST, 7, 1, 4));
            put(encI(corePkg::OP_BNEZ, 1, 2));
            put(encM(corePkg::OP_ST, 7, 3, 6));
            put(encI(corePkg::OP_BLTZ, 3, 2));
            put(encM(corePkg::OP_ST, 7, 3, 8));
            put(encI(corePkg::OP_BLTZ, 2, 2));
            put(encM(corePkg::OP_ST, 7, 2, 10));
            put(encI(corePkg::OP_BGEZ, 2, 2));
            put(encM(corePkg::OP_ST, 7, 1, 12));
            put(encI(corePkg::OP_BGEZ, 3, 2));
            put(encM(corePkg::OP_ST, 7, 3, 12));
            // backward loops
            put(encI(corePkg::OP_LBI, 4, 3));
            put(encM(corePkg::OP_ST, 7, 4, 14));
            put(encI(corePkg::OP_ADDI, 4, -1));
            put(encI(corePkg::OP_BNEZ, 4, -6));
            put(encI(corePkg::OP_LBI, 5, 2));
            put(encI(corePkg::OP_ADDI, 5, -1));
            put(encI(corePkg::OP_BGEZ, 5, -4));
            put(encM(corePkg::OP_ST, 7, 5, 16));
            put(encJ(2));
            put(encM(corePkg::OP_ST, 7, 1, 18));
         end
      endcase
      put({corePkg::OP_HALT, 11'h0});
   endtask

   // memory model, one request at a time with random wait states
   always @(negedge clk) begin
      if (wbAck) begin
         wbAck <= 1'b0;
      end else if (!rst && wbCyc && wbStb) begin
         if (waitLeft > 0) begin
            waitLeft--;
         end else begin
            if (wbWe) begin
               mem[wbAdr[8:1]] <= wbDatWr;
               dutAddr.push_back(wbAdr);
               dutData.push_back(wbDatWr);
            end
            wbDatRd <= mem[wbAdr[8:1]];
            wbAck <= 1'b1;
            waitLeft = useWaits ? ($random(seed) & 3) : 0;
         end
      end
   end

   // after halt, no fetch past the halt and halted stays up
   always @(negedge clk) begin
      if (checking && halted) haltSeen = 1'b1;
      if (checking && haltSeen) begin
         if (!halted) begin
            $display("halted dropped after the halt instruction");
            errors++;
         end
         if (wbCyc && wbAdr > haltPc) begin
            $display("bus request at %h past the halt at %h", wbAdr, haltPc);
            errors++;
         end
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (limit > 0 && cycles > limit) begin
         $display("timeout, the program did not reach halt in time");
         $display("sim failed");
         $finish;
      end
   end

   task automatic runTest(string name, int prog, bit waits);
      int errBefore;
      errBefore = errors;
      buildProgram(prog);
      void'(refRun());
      for (int i = 0; i < 256; i++) mem[i] = image[i];
      dutAddr.delete();
      dutData.delete();
      useWaits = waits;
      waitLeft = 0;
      checking = 0;
      haltSeen = 0;
      rst = 1'b1;
      repeat (10) begin
         @(negedge clk);
         checkWord("wbCyc in reset", 16'(wbCyc), 16'h0);
         checkWord("halted in reset", 16'(halted), 16'h0);
      end
      rst = 1'b0;
      checking = 1;
      @(negedge clk);
      checkWord("wbStb after reset", 16'(wbStb), 16'h0);
      checkWord("halted after reset", 16'(halted), 16'h0);
      while (!wbCyc) @(negedge clk);
      checkAddr("wbAdr first fetch", wbAdr, `CORE_RESET_PC);
      while (!halted) @(negedge clk);
      repeat (8) @(negedge clk);
      checkWord("store count", 16'(dutAddr.size()), 16'(refAddr.size()));
      for (int i = 0; i < dutAddr.size() && i < refAddr.size(); i++) begin
         checkAddr("store wbAdr", dutAddr[i], refAddr[i]);
         checkWord("store wbDatWr", dutData[i], refData[i]);
      end
      for (int i = 0; i < 256; i++) checkWord("final memory", mem[i], refMem[i]);
      checking = 0;
      if (errors == errBefore) begin
         passes++;
         $display("test %s: ok", name);
      end else begin
         fails++;
         $display("test %s: failed", name);
      end
   endtask

   initial begin
      int total;
      clk = 1'b0;
      rst = 1'b1;
      wbAck = 1'b0;
      wbDatRd = '0;
      errors = 0;
      passes = 0;
      fails = 0;
      cycles = 0;
      limit = 0;
      total = 0;
      // budget from the reference length of both runs of every program
      for (int p = 0; p < 3; p++) begin
         buildProgram(p);
         total += 2 * refRun();
      end
      limit = 40 * total + 6 * 30;
      runTest("arith", 0, 0);
      runTest("loadstore", 1, 0);
      runTest("branch", 2, 0);
      runTest("arith waits", 0, 1);
      runTest("loadstore waits", 1, 1);
      runTest("branch waits", 2, 1);
      $display("tests passed %0d failed %0d", passes, fails);
      if (fails == 0 && errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

/* build.f */
+incdir+include
rtl/corePkg.sv
rtl/coreIfs.sv
rtl/fetch.sv
rtl/decode.sv
rtl/execute.sv
rtl/wbArbiter.sv
rtl/cpuTop.sv
verification/cpuTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary -Wall -f build.f --top-module cpuTb -o cpuTbSim
out=$(./obj_dir/cpuTbSim)
echo "$out"
if echo "$out" | grep -qx "sim passed"; then
   exit 0
else
   exit 1
fi
